// File: rtl/mbist_params.svh
/* MBIST parameters: array geometry, data widths and the done drain depth */

`ifndef MBIST_PARAMS_SVH
`define MBIST_PARAMS_SVH

// Way and index addresses per array
`define MBIST_DC_DEPTH 512
`define MBIST_IC_DEPTH 1024

// March address counter covers the larger array
`define MBIST_ADDR_W 10

// Read data returned by each array
`define MBIST_DC_DATA_W 72
`define MBIST_IC_DATA_W 68

// Address split into way and index
`define MBIST_DC_INDEX_W 7
`define MBIST_IC_INDEX_W 8
`define MBIST_WAY_W 2

// Write byte, replicated across the word by the cache
`define MBIST_PATTERN_W 8

// Cycles from the last march op to done
`define MBIST_DRAIN_CYCLES 4

`endif

// File: rtl/mbist_march_pkg.sv
/* March algorithm types: elements, data backgrounds, control counter and
   the op issued to the cache port each cycle */

`default_nettype none

`include "mbist_params.svh"

package mbist_march_pkg;

  // Eight march elements, M6 and M7 take four phases per address
  typedef enum logic [2:0] {
    M0,
    M1,
    M2,
    M3,
    M4,
    M5,
    M6,
    M7
  } march_elem_e;

  typedef enum logic [1:0] {
    BG_AA,
    BG_99,
    BG_CC,
    BG_00
  } background_e;

  typedef enum logic {
    DCACHE,
    ICACHE
  } array_e;

  // Phase is innermost, so one increment steps a single access
  typedef struct packed {
    logic                      last;
    array_e                    array;
    background_e               background;
    logic                      word;
    march_elem_e               element;
    logic [`MBIST_ADDR_W-1:0]  address;
    logic [1:0]                phase;
  } march_ctrl_t;

  typedef struct packed {
    logic                         read;
    logic                         write;
    array_e                       array;
    logic                         word;
    logic [`MBIST_ADDR_W-1:0]     address;
    logic [`MBIST_PATTERN_W-1:0]  data;
  } march_op_t;

endpackage

`default_nettype wire

// File: rtl/mbist_cache_pkg.sv
/* Cache facing types: request strobes per array and the read check
   that follows a read to the compare stage */

`default_nettype none

`include "mbist_params.svh"

package mbist_cache_pkg;

  import mbist_march_pkg::*;

  typedef struct packed {
    logic                          read;
    logic                          write;
    logic                          word;
    logic [`MBIST_WAY_W-1:0]       way;
    logic [`MBIST_DC_INDEX_W-1:0]  index;
    logic [`MBIST_PATTERN_W-1:0]   wdata;
  } dc_req_t;

  typedef struct packed {
    logic                          read;
    logic                          write;
    logic                          word;
    logic [`MBIST_WAY_W-1:0]       way;
    logic [`MBIST_IC_INDEX_W-1:0]  index;
    logic [`MBIST_PATTERN_W-1:0]   wdata;
  } ic_req_t;

  // Expected byte of a read in flight
  typedef struct packed {
    logic                         valid;
    array_e                       array;
    logic [`MBIST_PATTERN_W-1:0]  expected;
  } read_check_t;

endpackage

`default_nettype wire

// File: rtl/mbist_config.sv
/* MBIST configuration: start edge detection, mode capture, run and done */

`default_nettype none

`include "mbist_params.svh"

module mbist_config (
  input  logic clk,
  input  logic arst_n,
  input  logic start,
  input  logic stop_on_fail,
  input  logic last,
  input  logic dc_fail,
  input  logic ic_fail,
  output logic restart,
  output logic run,
  output logic done
);

  logic [1:0]                     start_q;
  logic                           start_edge;
  logic                           init_q;
  logic                           sof_q;
  logic                           halt_q;
  logic                           fail_stop;
  logic [`MBIST_DRAIN_CYCLES-1:0] drain_q;

  ////////////////////////////////////////////////////////////////////////////
  // Start synchroniser and edge stage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      start_q <= '0;
      init_q  <= 1'b1;
    end else begin
      start_q <= {start_q[0], start};
      init_q  <= 1'b0;
    end
  end

  assign start_edge = start_q[0] & ~start_q[1];

  // One pulse on each rising start, and once out of reset
  assign restart = start_edge | init_q;

  // Mode is sampled only on the start edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sof_q <= 1'b0;
    end else if (start_edge) begin
      sof_q <= stop_on_fail;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Run and done
  ////////////////////////////////////////////////////////////////////////////

  assign fail_stop = sof_q & (dc_fail | ic_fail);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      halt_q  <= 1'b0;
      drain_q <= '0;
    end else if (restart) begin
      halt_q  <= 1'b0;
      drain_q <= '0;
    end else begin
      halt_q  <= halt_q | fail_stop;
      drain_q <= {drain_q[`MBIST_DRAIN_CYCLES-2:0], last};
    end
  end

  assign done = drain_q[`MBIST_DRAIN_CYCLES-1] | halt_q;

  // A fail in stop mode freezes the march at once, so the strobe of the
  // last op lands before done rises
  assign run = start_q[1] & ~done & ~fail_stop;

  a_restart_not_in_run : assert property (@(posedge clk) disable iff (!arst_n)
    !(restart && run));

endmodule

`default_nettype wire

// File: rtl/mbist_sequencer.sv
/* March sequencer: control counter stepping through arrays, backgrounds,
   words, elements and addresses, decoded into one op per cycle */

`default_nettype none

`include "mbist_params.svh"

module mbist_sequencer
  import mbist_march_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  input  logic      restart,
  input  logic      run,
  output march_op_t op,
  output logic      last
);

  march_ctrl_t               ctrl;
  march_ctrl_t               ctrl_nxt;
  logic                      active;
  logic                      four_phase;
  logic                      up_march;
  logic                      wr_sel;
  logic                      phase_wrap;
  logic                      addr_wrap;
  logic [1:0]                phase_nxt;
  logic [`MBIST_ADDR_W-1:0]  depth_m1;
  logic [`MBIST_ADDR_W-1:0]  addr_nxt;
  logic [7:0]                upper;
  logic [7:0]                upper_nxt;
  logic [`MBIST_PATTERN_W-1:0] pattern;

  assign four_phase = ctrl.element inside {M6, M7};
  assign up_march   = ctrl.element inside {M0, M1, M2, M6};

  assign depth_m1 = (ctrl.array == DCACHE) ? `MBIST_ADDR_W'(`MBIST_DC_DEPTH - 1)
                                           : `MBIST_ADDR_W'(`MBIST_IC_DEPTH - 1);

  ////////////////////////////////////////////////////////////////////////////
  // Control counter
  ////////////////////////////////////////////////////////////////////////////

  // Two-phase elements use phases 0 and 2 only
  always_comb begin
    phase_nxt  = ctrl.phase + (four_phase ? 2'd1 : 2'd2);
    phase_wrap = four_phase ? (ctrl.phase == 2'd3) : ctrl.phase[1];
    addr_wrap  = phase_wrap && (ctrl.address == depth_m1);

    addr_nxt = ctrl.address;
    if (phase_wrap) begin
      addr_nxt = addr_wrap ? '0 : ctrl.address + 1'b1;
    end

    // Element, word, background, array and last carry as one field
    upper     = {ctrl.last, ctrl.array, ctrl.background, ctrl.word, ctrl.element};
    upper_nxt = addr_wrap ? upper + 8'd1 : upper;

    ctrl_nxt = march_ctrl_t'({upper_nxt, addr_nxt, phase_nxt});
  end

  assign active = run & ~ctrl.last;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ctrl <= '0;
    end else if (restart) begin
      ctrl <= '0;
    end else if (active) begin
      ctrl <= ctrl_nxt;
    end
  end

  assign last = ctrl.last;

  ////////////////////////////////////////////////////////////////////////////
  // Op decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ctrl.background)
      BG_AA:   pattern = 8'hAA;
      BG_99:   pattern = 8'h99;
      BG_CC:   pattern = 8'hCC;
      default: pattern = 8'h00;
    endcase
  end

  // In M6 and M7 the middle two phases write
  assign wr_sel = four_phase ? (ctrl.phase[1] ^ ctrl.phase[0]) : ctrl.phase[1];

  always_comb begin
    op.write   = active & wr_sel;
    op.read    = active & ~wr_sel & (ctrl.element != M0);
    op.array   = ctrl.array;
    op.word    = ctrl.word;
    op.address = up_march ? ctrl.address : depth_m1 - ctrl.address;
    op.data    = (ctrl.phase[1] ^ ctrl.element[0]) ? pattern : ~pattern;
  end

  // One access per op, always inside the array the counter selects
  a_one_access : assert property (@(posedge clk) disable iff (!arst_n)
    (op.read || op.write) |-> (!(op.read && op.write) && (op.address <= depth_m1)));

endmodule

`default_nettype wire

// File: rtl/mbist_cache_port.sv
/* Cache port: registers the per-array request strobes and carries each
   read's expected byte to the compare stage */

`default_nettype none

`include "mbist_params.svh"

module mbist_cache_port
  import mbist_march_pkg::*;
  import mbist_cache_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  logic        restart,
  input  march_op_t   op,
  output dc_req_t     dc_req,
  output ic_req_t     ic_req,
  output read_check_t check
);

  logic        to_dc;
  read_check_t check_s1;

  assign to_dc = (op.array == DCACHE);

  ////////////////////////////////////////////////////////////////////////////
  // Request registers, one cycle after the op
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dc_req <= '0;
      ic_req <= '0;
    end else begin
      dc_req.read  <= op.read & to_dc & ~restart;
      dc_req.write <= op.write & to_dc & ~restart;
      dc_req.word  <= op.word;
      dc_req.way   <= op.address[`MBIST_DC_INDEX_W +: `MBIST_WAY_W];
      dc_req.index <= op.address[`MBIST_DC_INDEX_W-1:0];
      dc_req.wdata <= op.data;

      ic_req.read  <= op.read & ~to_dc & ~restart;
      ic_req.write <= op.write & ~to_dc & ~restart;
      ic_req.word  <= op.word;
      ic_req.way   <= op.address[`MBIST_IC_INDEX_W +: `MBIST_WAY_W];
      ic_req.index <= op.address[`MBIST_IC_INDEX_W-1:0];
      ic_req.wdata <= op.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read check pipe
  ////////////////////////////////////////////////////////////////////////////

  // Stage 1 sits beside the strobe, stage 2 beside the returned data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      check_s1 <= '0;
      check    <= '0;
    end else if (restart) begin
      check_s1 <= '0;
      check    <= '0;
    end else begin
      check_s1.valid    <= op.read;
      check_s1.array    <= op.array;
      check_s1.expected <= op.data;
      check             <= check_s1;
    end
  end

endmodule

`default_nettype wire

// File: rtl/mbist_comparator.sv
/* Read compare: captures the returned word, checks it against the
   replicated expected byte and keeps a sticky fail flag per array */

`default_nettype none

`include "mbist_params.svh"

module mbist_comparator
  import mbist_march_pkg::*;
  import mbist_cache_pkg::*;
(
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         restart,
  input  read_check_t                  check,
  input  logic [`MBIST_DC_DATA_W-1:0]  dc_data_in,
  input  logic [`MBIST_IC_DATA_W-1:0]  ic_data_in,
  output logic                         dc_fail,
  output logic                         ic_fail
);

  localparam int REP = `MBIST_DC_DATA_W / `MBIST_PATTERN_W;

  read_check_t                  check_q;
  logic [`MBIST_DC_DATA_W-1:0]  data_q;
  logic [`MBIST_DC_DATA_W-1:0]  expect_word;
  logic                         dc_miss;
  logic                         ic_miss;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      check_q <= '0;
    end else if (restart) begin
      check_q <= '0;
    end else begin
      check_q <= check;
    end
  end

  // Icache data is zero extended, upper bits are never compared
  always_ff @(posedge clk) begin
    data_q <= (check.array == DCACHE) ? dc_data_in : `MBIST_DC_DATA_W'(ic_data_in);
  end

  assign expect_word = {REP{check_q.expected}};

  assign dc_miss = check_q.valid && (check_q.array == DCACHE) && (data_q != expect_word);
  assign ic_miss = check_q.valid && (check_q.array == ICACHE) &&
                   (data_q[`MBIST_IC_DATA_W-1:0] != expect_word[`MBIST_IC_DATA_W-1:0]);

  ////////////////////////////////////////////////////////////////////////////
  // Sticky fail flags
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dc_fail <= 1'b0;
      ic_fail <= 1'b0;
    end else if (restart) begin
      dc_fail <= 1'b0;
      ic_fail <= 1'b0;
    end else begin
      dc_fail <= dc_fail | dc_miss;
      ic_fail <= ic_fail | ic_miss;
    end
  end

  a_dc_fail_cause : assert property (@(posedge clk) disable iff (!arst_n)
    $rose(dc_fail) |-> $past(check_q.valid && check_q.array == DCACHE));

  a_ic_fail_cause : assert property (@(posedge clk) disable iff (!arst_n)
    $rose(ic_fail) |-> $past(check_q.valid && check_q.array == ICACHE));

endmodule

`default_nettype wire

// File: rtl/mbist_top.sv
/* MBIST controller for the first-level data and instruction caches */

`default_nettype none

`include "mbist_params.svh"

module mbist_top
  import mbist_march_pkg::*;
  import mbist_cache_pkg::*;
(
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         start,
  input  logic                         stop_on_fail,
  input  logic [`MBIST_DC_DATA_W-1:0]  dc_data_in,
  input  logic [`MBIST_IC_DATA_W-1:0]  ic_data_in,
  output dc_req_t                      dc_req,
  output ic_req_t                      ic_req,
  output logic                         run,
  output logic                         done,
  output logic                         dc_fail,
  output logic                         ic_fail
);

  logic        restart;
  logic        last;
  march_op_t   op;
  read_check_t check;

  mbist_config u_config (
    .clk          (clk),
    .arst_n       (arst_n),
    .start        (start),
    .stop_on_fail (stop_on_fail),
    .last         (last),
    .dc_fail      (dc_fail),
    .ic_fail      (ic_fail),
    .restart      (restart),
    .run          (run),
    .done         (done)
  );

  mbist_sequencer u_sequencer (
    .clk     (clk),
    .arst_n  (arst_n),
    .restart (restart),
    .run     (run),
    .op      (op),
    .last    (last)
  );

  mbist_cache_port u_cache_port (
    .clk     (clk),
    .arst_n  (arst_n),
    .restart (restart),
    .op      (op),
    .dc_req  (dc_req),
    .ic_req  (ic_req),
    .check   (check)
  );

  mbist_comparator u_comparator (
    .clk        (clk),
    .arst_n     (arst_n),
    .restart    (restart),
    .check      (check),
    .dc_data_in (dc_data_in),
    .ic_data_in (ic_data_in),
    .dc_fail    (dc_fail),
    .ic_fail    (ic_fail)
  );

endmodule

`default_nettype wire

// File: verification/mbist_checker.sv
/* MBIST checker: strobe protocol, request counts, fail flags at the end of
   each test and the closing counts */

`default_nettype none

`include "mbist_params.svh"

module mbist_checker
  import mbist_cache_pkg::*;
(
  input  logic       clk,
  input  logic       arst_n,
  input  logic       start,
  input  dc_req_t    dc_req,
  input  ic_req_t    ic_req,
  input  logic       run,
  input  logic       done,
  input  logic       dc_fail,
  input  logic       ic_fail,
  input  logic       test_end,
  input  logic [2:0] test_id,
  input  logic       exp_dc_fail,
  input  logic       exp_ic_fail,
  input  logic [1:0] count_mode,
  input  logic       report,
  output int         fail_total
);

  // 10 writes and 9 reads per address, per background and word
  localparam int WRITES_PER_RUN = 80 * (`MBIST_DC_DEPTH + `MBIST_IC_DEPTH);
  localparam int READS_PER_RUN  = 72 * (`MBIST_DC_DEPTH + `MBIST_IC_DEPTH);

  int   writes;
  int   reads;
  int   word_writes;
  int   run_errs;
  int   errors;
  int   passed;
  int   failed;
  logic start_q;
  logic fresh;
  logic test_ok;
  logic dc_strobe;
  logic ic_strobe;

  assign dc_strobe = dc_req.read | dc_req.write;
  assign ic_strobe = ic_req.read | ic_req.write;

  task automatic flag_error(input string what);
    $display("Error at %0t: %s", $time, what);
    errors++;
    run_errs++;
    test_ok = 1'b0;
  endtask

  task automatic expect_value(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, got);
      errors++;
      run_errs++;
      test_ok = 1'b0;
    end
  endtask

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "clean run";
      3'd2:    return "request counts and protocol";
      3'd3:    return "dcache fault";
      3'd4:    return "icache fault with stop on fail";
      default: return "restart";
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Cycle checks
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!arst_n) begin
      fresh      = 1'b0;
      fail_total = 0;
    end else begin
      // New run begins at the start edge
      if (start && !start_q) begin
        writes      = 0;
        reads       = 0;
        word_writes = 0;
        run_errs    = 0;
        fresh       = 1'b1;
      end
      if ((dc_req.read && dc_req.write) || (ic_req.read && ic_req.write) ||
          (dc_strobe && ic_strobe)) begin
        flag_error("more than one cache strobe high in one cycle");
      end
      if ((dc_strobe || ic_strobe) && done) begin
        flag_error("cache strobe issued while done is high");
      end
      if ((dc_strobe || ic_strobe) && fresh) begin
        expect_value("dc_fail", int'(dc_fail), 0);
        expect_value("ic_fail", int'(ic_fail), 0);
        fresh = 1'b0;
      end
      writes = writes + int'(dc_req.write) + int'(ic_req.write);
      reads  = reads + int'(dc_req.read) + int'(ic_req.read);
      word_writes = word_writes + int'(dc_req.write && dc_req.word) +
                    int'(ic_req.write && ic_req.word);

      if (test_end) begin
        test_ok = (run_errs == 0);
        expect_value("done", int'(done), 1);
        expect_value("run", int'(run), 0);
        expect_value("dc_fail", int'(dc_fail), int'(exp_dc_fail));
        expect_value("ic_fail", int'(ic_fail), int'(exp_ic_fail));
        case (count_mode)
          2'd1: begin
            expect_value("write strobe count", writes, WRITES_PER_RUN);
            expect_value("read strobe count", reads, READS_PER_RUN);
            // Both words of each line take half of the writes
            expect_value("second word write count", word_writes, WRITES_PER_RUN / 2);
          end
          2'd2: begin
            if (writes >= WRITES_PER_RUN) begin
              flag_error("run was not cut short by the fail");
            end
          end
          default: ;
        endcase
        $display("Test %0d %s: %s", test_id, test_name(test_id), test_ok ? "pass" : "FAIL");
        if (test_ok) begin
          passed++;
        end else begin
          failed++;
        end
      end

      if (report) begin
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 passed + failed, passed, failed, errors);
        fail_total = failed + errors;
      end
    end
    start_q = start;
  end

endmodule

`default_nettype wire

// File: verification/tb_mbist_top.sv
/* MBIST testbench: clock, reset, cache models with stuck-bit faults and
   the run sequence */

`default_nettype none

`include "mbist_params.svh"

module tb_mbist_top
  import mbist_cache_pkg::*;
();

  localparam int SEED       = 32'h5a6af298;
  localparam int RUN_CYCLES = 160 * (`MBIST_DC_DEPTH + `MBIST_IC_DEPTH);
  localparam int MAX_CYCLES = 4 * RUN_CYCLES + 200000;
  localparam int DC_WORDS   = 2 * `MBIST_DC_DEPTH;
  localparam int IC_WORDS   = 2 * `MBIST_IC_DEPTH;
  localparam int DC_REP     = `MBIST_DC_DATA_W / `MBIST_PATTERN_W;
  localparam int IC_REP     = (`MBIST_IC_DATA_W + `MBIST_PATTERN_W - 1) / `MBIST_PATTERN_W;

  logic                         clk = 1'b0;
  logic                         arst_n;
  logic                         start;
  logic                         stop_on_fail;
  logic [`MBIST_DC_DATA_W-1:0]  dc_data_in = '0;
  logic [`MBIST_IC_DATA_W-1:0]  ic_data_in = '0;
  dc_req_t                      dc_req;
  ic_req_t                      ic_req;
  logic                         run;
  logic                         done;
  logic                         dc_fail;
  logic                         ic_fail;

  // Test control towards the checker
  logic       test_end;
  logic       report;
  logic [2:0] test_id;
  logic       exp_dc_fail;
  logic       exp_ic_fail;
  logic [1:0] count_mode;
  int         fail_total;
  int         cycles = 0;

  // Cache contents keyed by {word, way, index}
  logic [`MBIST_PATTERN_W-1:0] dc_mem [DC_WORDS];
  logic [`MBIST_PATTERN_W-1:0] ic_mem [IC_WORDS];

  logic        dc_fault_en;
  logic [9:0]  dc_fault_loc;
  int          dc_fault_bit;
  logic        dc_fault_val;
  logic        ic_fault_en;
  logic [10:0] ic_fault_loc;
  int          ic_fault_bit;
  logic        ic_fault_val;

  always #4 clk = ~clk;

  mbist_top DUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .start        (start),
    .stop_on_fail (stop_on_fail),
    .dc_data_in   (dc_data_in),
    .ic_data_in   (ic_data_in),
    .dc_req       (dc_req),
    .ic_req       (ic_req),
    .run          (run),
    .done         (done),
    .dc_fail      (dc_fail),
    .ic_fail      (ic_fail)
  );

  mbist_checker u_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .dc_req      (dc_req),
    .ic_req      (ic_req),
    .run         (run),
    .done        (done),
    .dc_fail     (dc_fail),
    .ic_fail     (ic_fail),
    .test_end    (test_end),
    .test_id     (test_id),
    .exp_dc_fail (exp_dc_fail),
    .exp_ic_fail (exp_ic_fail),
    .count_mode  (count_mode),
    .report      (report),
    .fail_total  (fail_total)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Cache models, read data returned the cycle after the strobe
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : dc_model
    logic [9:0]                   key;
    logic [`MBIST_DC_DATA_W-1:0]  rdata;
    key   = {dc_req.word, dc_req.way, dc_req.index};
    rdata = {DC_REP{dc_mem[key]}};
    if (dc_fault_en && key == dc_fault_loc) begin
      rdata[dc_fault_bit] = dc_fault_val;
    end
    if (dc_req.read) begin
      dc_data_in <= rdata;
    end
    if (dc_req.write) begin
      dc_mem[key] <= dc_req.wdata;
    end
  end

  always @(posedge clk) begin : ic_model
    logic [10:0]                  key;
    logic [`MBIST_IC_DATA_W-1:0]  rdata;
    key   = {ic_req.word, ic_req.way, ic_req.index};
    rdata = `MBIST_IC_DATA_W'({IC_REP{ic_mem[key]}});
    if (ic_fault_en && key == ic_fault_loc) begin
      rdata[ic_fault_bit] = ic_fault_val;
    end
    if (ic_req.read) begin
      ic_data_in <= rdata;
    end
    if (ic_req.write) begin
      ic_mem[key] <= ic_req.wdata;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the run never reached done", cycles);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequence helpers
  ////////////////////////////////////////////////////////////////////////////

  // Drop start, raise it again and wait for the run to finish
  task automatic march_run(input logic sof);
    @(posedge clk);
    #1 start = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    stop_on_fail = sof;
    start        = 1'b1;
    @(negedge clk);
    while (!run) @(negedge clk);
    while (!done) @(negedge clk);
  endtask

  task automatic end_test(input logic [2:0] id, input logic dc_exp, input logic ic_exp,
                          input logic [1:0] mode);
    @(posedge clk);
    #1;
    test_id     = id;
    exp_dc_fail = dc_exp;
    exp_ic_fail = ic_exp;
    count_mode  = mode;
    test_end    = 1'b1;
    @(posedge clk);
    #1 test_end = 1'b0;
  endtask

  task automatic inject_fault(input logic to_icache);
    if (to_icache) begin
      ic_fault_loc = 11'($urandom % IC_WORDS);
      ic_fault_bit = int'($urandom % `MBIST_IC_DATA_W);
      ic_fault_val = 1'($urandom % 2);
      ic_fault_en  = 1'b1;
      $display("Icache stuck-at-%0d on entry %0d bit %0d", ic_fault_val, ic_fault_loc,
               ic_fault_bit);
    end else begin
      dc_fault_loc = 10'($urandom % DC_WORDS);
      dc_fault_bit = int'($urandom % `MBIST_DC_DATA_W);
      dc_fault_val = 1'($urandom % 2);
      dc_fault_en  = 1'b1;
      $display("Dcache stuck-at-%0d on entry %0d bit %0d", dc_fault_val, dc_fault_loc,
               dc_fault_bit);
    end
  endtask

  task automatic clear_faults;
    dc_fault_en = 1'b0;
    ic_fault_en = 1'b0;
  endtask

  initial begin : stimulus
    void'($urandom(SEED));
    arst_n       = 1'b0;
    start        = 1'b0;
    stop_on_fail = 1'b0;
    test_end     = 1'b0;
    report       = 1'b0;
    test_id      = '0;
    exp_dc_fail  = 1'b0;
    exp_ic_fail  = 1'b0;
    count_mode   = '0;
    dc_fault_loc = '0;
    dc_fault_bit = 0;
    dc_fault_val = 1'b0;
    ic_fault_loc = '0;
    ic_fault_bit = 0;
    ic_fault_val = 1'b0;
    clear_faults();
    repeat (8) @(posedge clk);
    #1 arst_n = 1'b1;
    repeat (4) @(posedge clk);

    march_run(1'b0);
    end_test(3'd1, 1'b0, 1'b0, 2'd0);
    end_test(3'd2, 1'b0, 1'b0, 2'd1);

    inject_fault(1'b0);
    march_run(1'b0);
    end_test(3'd3, 1'b1, 1'b0, 2'd1);

    clear_faults();
    inject_fault(1'b1);
    march_run(1'b1);
    end_test(3'd4, 1'b0, 1'b1, 2'd2);

    // Flags from the previous run must clear on the new start edge
    clear_faults();
    march_run(1'b0);
    end_test(3'd5, 1'b0, 1'b0, 2'd1);

    @(posedge clk);
    #1 report = 1'b1;
    @(posedge clk);
    #1 report = 1'b0;
    if (fail_total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+rtl
rtl/mbist_march_pkg.sv
rtl/mbist_cache_pkg.sv
rtl/mbist_config.sv
rtl/mbist_sequencer.sv
rtl/mbist_cache_port.sv
rtl/mbist_comparator.sv
rtl/mbist_top.sv
verification/mbist_checker.sv
verification/tb_mbist_top.sv

// File: Makefile
# Verilator build and run for the MBIST controller testbench

VERILATOR ?= verilator
TOP       ?= tb_mbist_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test completed successfully

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) rtl/mbist_params.svh

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run fails unless the pass message appears on a line of its own
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
